// File: logic/ibus_pkg.sv
package ibus_pkg;

  // ========================================
  // bus geometry
  // ========================================

  localparam int BUS_AW  = 32;          // byte address on the bus
  localparam int DATA_W  = 32;
  localparam int WORD_AW = BUS_AW - 2;  // one word is four bytes
  localparam int HW_AW   = WORD_AW + 1; // halfword granularity from the core

  // ========================================
  // address and data vectors
  // ========================================

  // redirect target from the core, bit 0 picks the upper halfword
  typedef logic [HW_AW-1:0] hw_addr_t;

  typedef logic [WORD_AW-1:0] word_addr_t;

  // always word aligned when driven by the fetch unit
  typedef logic [BUS_AW-1:0] bus_addr_t;

  typedef logic [DATA_W-1:0] word_t;

endpackage

// File: logic/fetch_pkg.sv
package fetch_pkg;

  // ========================================
  // request queue entry
  // ========================================

  // one entry carries the word address plus the unaligned start flag
  localparam int FETCH_REQ_W     = ibus_pkg::WORD_AW + 1;
  localparam int REQ_UNALIGN_BIT = ibus_pkg::WORD_AW; // flag sits above the address

  typedef logic [FETCH_REQ_W-1:0] fetch_req_t;

  // ========================================
  // state machines
  // ========================================

  // bus master, one classic cycle at a time
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ACK,  // cyc and stb are up
    ST_DELIVER    // registered word goes out to the core
  } mst_state_t;

  // tracks a bus cycle whose data must be thrown away
  typedef enum logic {
    AB_IDLE,
    AB_VLD
  } abort_state_t;

endpackage

// File: logic/fetch_addr_gen.sv
`timescale 1ns/1ns

module fetch_addr_gen #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                  sm_upd_clk,
  input  logic                  cpurst_b,
  input  logic                  redirect_vld,
  input  logic                  fetch_en,
  input  logic                  lpmd_req,
  input  ibus_pkg::hw_addr_t    redirect_addr,
  input  logic                  full,
  output logic                  push,
  output fetch_pkg::fetch_req_t push_req
);

  import ibus_pkg::*;

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(QUEUE_DEPTH);

  word_addr_t       addr_cnt;
  logic             unalign_pend;      // first word after an odd halfword redirect
  logic [CNT_W-1:0] push_since_flush;

  // ========================================
  // request push
  // ========================================

  // no push in the redirect cycle since the queue is being flushed
  assign push = fetch_en && !lpmd_req && !full && !redirect_vld;

  assign push_req = {unalign_pend, addr_cnt};

  // ========================================
  // sequential word counter
  // ========================================

  always_ff @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      addr_cnt     <= '0;
      unalign_pend <= 1'b0;
    end
    else if (redirect_vld)
    begin
      addr_cnt     <= redirect_addr[WORD_AW:1]; // drop the halfword select
      unalign_pend <= redirect_addr[0];
    end
    else if (push)
    begin
      addr_cnt     <= addr_cnt + 1'b1;
      unalign_pend <= 1'b0;  // only the first word of a new stream is unaligned
    end
  end

  // pushes issued since the queue was last emptied, saturating at the depth
  always_ff @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      push_since_flush <= '0;
    else if (redirect_vld)
      push_since_flush <= '0;
    else if (push && (push_since_flush != CNT_MAX))
      push_since_flush <= push_since_flush + 1'b1;
  end

  // the queue can only fill after this side has handed over a whole queue's worth
  a_full_after_depth_pushes: assert property (
    @(posedge sm_upd_clk) disable iff (!cpurst_b)
    $rose(full) |-> (push_since_flush == CNT_MAX)
  );

endmodule

// File: logic/fetch_req_queue.sv
`timescale 1ns/1ns

module fetch_req_queue #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                  sm_upd_clk,
  input  logic                  cpurst_b,
  input  logic                  flush,
  input  logic                  push,
  input  logic                  pop,
  input  fetch_pkg::fetch_req_t push_req,
  output logic                  full,
  output logic                  empty,
  output logic                  req_vld,
  output fetch_pkg::fetch_req_t head_req
);

  import fetch_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

  fetch_req_t       mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  assign full  = (count == DEPTH_CNT);
  assign empty = (count == '0);

  // the head is stale while a redirect flushes the queue
  assign req_vld  = !empty && !flush;
  assign head_req = mem[rd_ptr];

  // ========================================
  // storage
  // ========================================

  always_ff @(posedge sm_upd_clk)
  begin
    if (push && !flush)
      mem[wr_ptr] <= push_req;
  end

  // ========================================
  // pointers and occupancy
  // ========================================

  // power of two depth, so the pointers wrap by themselves
  always_ff @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the master may only take an entry that is really there
  a_no_pop_empty: assert property (
    @(posedge sm_upd_clk) disable iff (!cpurst_b)
    pop |-> !empty
  );

  // the producer has to honour full
  a_no_push_full: assert property (
    @(posedge sm_upd_clk) disable iff (!cpurst_b)
    push |-> !full
  );

endmodule

// File: logic/ibus_master.sv
`timescale 1ns/1ns

module ibus_master (
  input  logic                  sm_upd_clk,
  input  logic                  cpurst_b,
  input  logic                  redirect_vld,
  input  logic                  lpmd_req,
  input  logic                  req_vld,
  input  logic                  empty,
  input  fetch_pkg::fetch_req_t head_req,
  output logic                  pop,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output ibus_pkg::bus_addr_t   wb_adr,
  input  ibus_pkg::word_t       wb_dat,
  input  logic                  wb_ack,
  input  logic                  wb_err,
  output logic                  inst_vld,
  output ibus_pkg::word_t       inst_data,
  output logic                  inst_16bit,
  output logic                  inst_unalign,
  output logic                  inst_acc_err,
  output logic                  lpmd_ack
);

  import ibus_pkg::*;
  import fetch_pkg::*;

  mst_state_t   cur_st;
  mst_state_t   nxt_st;
  abort_state_t ab_cur_st;
  abort_state_t ab_nxt_st;

  word_addr_t cyc_addr;
  logic       cyc_unalign;
  logic       bus_done;
  logic       cyc_abort;
  word_t      dlv_data;
  logic       dlv_err;

  // ========================================
  // main FSM
  // ========================================

  assign bus_done  = (cur_st == ST_WAIT_ACK) && (wb_ack || wb_err);
  assign cyc_abort = (ab_cur_st == AB_VLD) || redirect_vld; // a late redirect also kills it
  assign pop       = (cur_st == ST_IDLE) && req_vld;

  always_ff @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_st <= ST_IDLE;
    else
      cur_st <= nxt_st;
  end

  always_comb
  begin
    nxt_st = cur_st;
    case (cur_st)
      ST_IDLE:
        if (req_vld)
          nxt_st = ST_WAIT_ACK;
      ST_WAIT_ACK:
        if (bus_done)
          nxt_st = cyc_abort ? ST_IDLE : ST_DELIVER;
      ST_DELIVER:
        nxt_st = ST_IDLE;
      default:
        nxt_st = ST_IDLE;
    endcase
  end

  // ========================================
  // abort tracking
  // ========================================

  always_ff @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ab_cur_st <= AB_IDLE;
    else
      ab_cur_st <= ab_nxt_st;
  end

  always_comb
  begin
    ab_nxt_st = ab_cur_st;
    case (ab_cur_st)
      AB_IDLE:
        if (redirect_vld && (cur_st == ST_WAIT_ACK) && !bus_done)
          ab_nxt_st = AB_VLD;
      AB_VLD:
        if (bus_done)
          ab_nxt_st = AB_IDLE;
      default:
        ab_nxt_st = AB_IDLE;
    endcase
  end

  // ========================================
  // popped entry and returned data
  // ========================================

  always_ff @(posedge sm_upd_clk)
  begin
    if (pop)
      cyc_addr <= head_req[WORD_AW-1:0];
  end

  always_ff @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cyc_unalign <= 1'b0;
    else if (pop)
      cyc_unalign <= head_req[REQ_UNALIGN_BIT];
  end

  // an unaligned start only has its upper halfword to offer
  always_ff @(posedge sm_upd_clk)
  begin
    if (bus_done)
    begin
      dlv_data <= {wb_dat[31:16], cyc_unalign ? wb_dat[31:16] : wb_dat[15:0]};
      dlv_err  <= wb_err;
    end
  end

  assign wb_cyc = (cur_st == ST_WAIT_ACK);
  assign wb_stb = (cur_st == ST_WAIT_ACK);
  assign wb_adr = {cyc_addr, 2'b00};

  // a redirect in the delivery cycle makes this word stale as well
  assign inst_vld     = (cur_st == ST_DELIVER) && !redirect_vld;
  assign inst_data    = dlv_data;
  assign inst_16bit   = (dlv_data[1:0] != 2'b11);
  assign inst_unalign = cyc_unalign;
  assign inst_acc_err = dlv_err;

  assign lpmd_ack = lpmd_req && (cur_st == ST_IDLE) && empty;

  // classic cycle holds until the slave answers
  a_cycle_hold: assert property (
    @(posedge sm_upd_clk) disable iff (!cpurst_b)
    wb_stb && !(wb_ack || wb_err) |=> wb_cyc && wb_stb && $stable(wb_adr)
  );

endmodule

// File: logic/ifu_ibusif.sv
`timescale 1ns/1ns

module ifu_ibusif #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                sm_upd_clk,
  input  logic                cpurst_b,
  // core side
  input  logic                redirect_vld,
  input  ibus_pkg::hw_addr_t  redirect_addr,
  input  logic                fetch_en,
  input  logic                lpmd_req,
  output logic                inst_vld,
  output ibus_pkg::word_t     inst_data,
  output logic                inst_16bit,
  output logic                inst_unalign,
  output logic                inst_acc_err,
  output logic                lpmd_ack,
  // wishbone toward memory
  output logic                wb_cyc,
  output logic                wb_stb,
  output ibus_pkg::bus_addr_t wb_adr,
  input  ibus_pkg::word_t     wb_dat,
  input  logic                wb_ack,
  input  logic                wb_err
);

  import fetch_pkg::*;

  logic       push;
  logic       pop;
  logic       full;
  logic       empty;
  logic       req_vld;
  fetch_req_t push_req;
  fetch_req_t head_req;

  // ========================================
  // producer, queue, bus master
  // ========================================

  fetch_addr_gen #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_fetch_addr_gen (
    .sm_upd_clk    (sm_upd_clk),
    .cpurst_b      (cpurst_b),
    .redirect_vld  (redirect_vld),
    .fetch_en      (fetch_en),
    .lpmd_req      (lpmd_req),
    .redirect_addr (redirect_addr),
    .full          (full),
    .push          (push),
    .push_req      (push_req)
  );

  // a redirect throws away everything still queued
  fetch_req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_fetch_req_queue (
    .sm_upd_clk (sm_upd_clk),
    .cpurst_b   (cpurst_b),
    .flush      (redirect_vld),
    .push       (push),
    .pop        (pop),
    .push_req   (push_req),
    .full       (full),
    .empty      (empty),
    .req_vld    (req_vld),
    .head_req   (head_req)
  );

  ibus_master i_ibus_master (
    .sm_upd_clk   (sm_upd_clk),
    .cpurst_b     (cpurst_b),
    .redirect_vld (redirect_vld),
    .lpmd_req     (lpmd_req),
    .req_vld      (req_vld),
    .empty        (empty),
    .head_req     (head_req),
    .pop          (pop),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_dat       (wb_dat),
    .wb_ack       (wb_ack),
    .wb_err       (wb_err),
    .inst_vld     (inst_vld),
    .inst_data    (inst_data),
    .inst_16bit   (inst_16bit),
    .inst_unalign (inst_unalign),
    .inst_acc_err (inst_acc_err),
    .lpmd_ack     (lpmd_ack)
  );

endmodule

// File: test/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 16
) (
  output logic sm_upd_clk,
  output logic cpurst_b
);

  initial
  begin
    sm_upd_clk = 1'b0;
    forever #(PERIOD_NS / 2) sm_upd_clk = ~sm_upd_clk;
  end

  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge sm_upd_clk);
    #1 cpurst_b = 1'b1; // released off the edge like the other inputs
  end

endmodule

// File: test/tb_ifu_ibusif.sv
`timescale 1ns/1ns

module tb_ifu_ibusif;

  import ibus_pkg::*;

  localparam int          QUEUE_DEPTH = 2;
  localparam int          WAIT_LIMIT  = 500;
  localparam int unsigned LONG_WAIT   = 10;
  localparam word_t       DATA_KEY    = 32'h5a5a_1234;
  localparam bus_addr_t   ERR_ADDR    = 32'h0000_0414;
  localparam word_addr_t  ERR_WADDR   = ERR_ADDR[31:2];
  localparam hw_addr_t    START_HW    = 31'h0000_0200; // word 0x100, runs over the error word
  localparam hw_addr_t    ODD_HW      = 31'h0000_8081; // upper half of this word is 32-bit
  localparam hw_addr_t    FLIGHT_HW   = 31'h0000_1000;

  logic sm_upd_clk;
  logic cpurst_b;
  logic redirect_vld;
  hw_addr_t redirect_addr;
  logic fetch_en;
  logic lpmd_req;
  logic inst_vld;
  word_t inst_data;
  logic inst_16bit;
  logic inst_unalign;
  logic inst_acc_err;
  logic lpmd_ack;
  logic wb_cyc;
  logic wb_stb;
  bus_addr_t wb_adr;
  word_t wb_dat;
  logic wb_ack;
  logic wb_err;

  int errors;
  int timeouts;
  int inst_count;
  int unalign_seen;
  int wide_seen;
  int err_seen;
  int flight_seen;
  int lpmd_seen;

  word_addr_t exp_waddr;
  logic       exp_unalign;
  word_t      exp_data;
  logic       exp_err;

  logic        long_ack;   // next bus cycle gets the slow answer
  logic        mem_busy;
  logic        long_cyc;
  int unsigned ack_wait;

  tb_clkgen #(.PERIOD_NS(8), .RST_CYCLES(16)) i_tb_clkgen (
    .sm_upd_clk (sm_upd_clk),
    .cpurst_b   (cpurst_b)
  );

  ifu_ibusif #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_ifu_ibusif (
    .sm_upd_clk    (sm_upd_clk),
    .cpurst_b      (cpurst_b),
    .redirect_vld  (redirect_vld),
    .redirect_addr (redirect_addr),
    .fetch_en      (fetch_en),
    .lpmd_req      (lpmd_req),
    .inst_vld      (inst_vld),
    .inst_data     (inst_data),
    .inst_16bit    (inst_16bit),
    .inst_unalign  (inst_unalign),
    .inst_acc_err  (inst_acc_err),
    .lpmd_ack      (lpmd_ack),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_adr        (wb_adr),
    .wb_dat        (wb_dat),
    .wb_ack        (wb_ack),
    .wb_err        (wb_err)
  );

  function automatic word_t mem_word(input bus_addr_t adr);
    return adr ^ DATA_KEY;
  endfunction

  function automatic word_t expected_inst(input word_addr_t waddr, input logic unalign);
    word_t w;
    w = mem_word({waddr, 2'b00});
    if (unalign)
      w[15:0] = w[31:16]; // only the upper halfword belongs to the new stream
    return w;
  endfunction

  task automatic report_value(input string sig, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    errors++;
    $display("ERROR %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
  endtask

  task automatic report_rule(input string what);
    errors++;
    $display("FAILED at %0t ns: %s", $time, what);
  endtask

  // ========================================
  // memory model
  // ========================================

  always @(posedge sm_upd_clk)
  begin
    logic      req_open;
    logic      answer;
    bus_addr_t req_adr;
    req_open = wb_cyc && wb_stb && !wb_ack && !wb_err;
    req_adr  = wb_adr;
    answer   = 1'b0;
    if (!req_open)
      mem_busy = 1'b0;
    else if (!mem_busy)
    begin
      mem_busy = 1'b1;
      long_cyc = long_ack;
      ack_wait = long_ack ? LONG_WAIT : $urandom_range(3, 0);
      answer   = (ack_wait == 0);
    end
    else
    begin
      ack_wait = ack_wait - 1;
      answer   = (ack_wait == 0);
    end
    #1;
    wb_ack = answer && (req_adr != ERR_ADDR);
    wb_err = answer && (req_adr == ERR_ADDR);
    wb_dat = answer ? mem_word(req_adr) : '0;
  end

  // ========================================
  // expected stream and reach counters
  // ========================================

  assign exp_data = expected_inst(exp_waddr, exp_unalign);
  assign exp_err  = (exp_waddr == ERR_WADDR);

  always @(posedge sm_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      exp_waddr   <= '0;
      exp_unalign <= 1'b0;
    end
    else if (redirect_vld)
    begin
      exp_waddr   <= redirect_addr[WORD_AW:1];
      exp_unalign <= redirect_addr[0];
    end
    else if (inst_vld)
    begin
      exp_waddr   <= exp_waddr + 1'b1;
      exp_unalign <= 1'b0;
    end
  end

  always @(posedge sm_upd_clk)
  begin
    if (inst_vld)
    begin
      inst_count   <= inst_count + 1;
      unalign_seen <= unalign_seen + int'(inst_unalign);
      wide_seen    <= wide_seen + int'(!inst_16bit);
      err_seen     <= err_seen + int'(inst_acc_err);
    end
    flight_seen <= flight_seen + int'(redirect_vld && wb_cyc);
    lpmd_seen   <= lpmd_seen + int'(lpmd_ack);
  end

  // ========================================
  // checks
  // ========================================

  a_inst_data: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    inst_vld |-> inst_data == exp_data)
    else report_value("inst_data", $sampled(exp_data), $sampled(inst_data));

  a_inst_unalign: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    inst_vld |-> inst_unalign == exp_unalign)
    else report_value("inst_unalign", $sampled(exp_unalign), $sampled(inst_unalign));

  // 32-bit only when both low bits are set
  a_inst_16bit: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    inst_vld |-> inst_16bit == (exp_data[1:0] != 2'b11))
    else report_value("inst_16bit", $sampled(exp_data[1:0] != 2'b11), $sampled(inst_16bit));

  a_inst_acc_err: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    inst_vld |-> inst_acc_err == exp_err)
    else report_value("inst_acc_err", $sampled(exp_err), $sampled(inst_acc_err));

  a_stb_in_cyc: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    wb_stb |-> wb_cyc)
    else report_rule("wb_stb is high without wb_cyc");

  a_cyc_hold: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    wb_cyc && !wb_ack && !wb_err |=> wb_cyc && wb_stb)
    else report_rule("bus cycle dropped before the memory answered");

  a_adr_hold: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    wb_cyc && !wb_ack && !wb_err |=> $stable(wb_adr))
    else report_rule("wb_adr changed while the bus cycle was waiting");

  a_adr_word: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    wb_cyc |-> wb_adr[1:0] == 2'b00)
    else report_value("wb_adr", {$sampled(wb_adr[31:2]), 2'b00}, $sampled(wb_adr));

  a_lpmd_quiet: assert property (@(posedge sm_upd_clk) disable iff (!cpurst_b)
    lpmd_ack |-> !wb_cyc && !inst_vld)
    else report_rule("bus or core activity while low power is acknowledged");

  // ========================================
  // stimulus
  // ========================================

  task automatic to_drive_point();
    @(posedge sm_upd_clk);
    #1;
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("TIMEOUT at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) to_drive_point();
  endtask

  task automatic wait_reset_release();
    int guard;
    guard = 0;
    while (!cpurst_b && (guard < WAIT_LIMIT))
    begin
      @(negedge sm_upd_clk);
      guard++;
    end
    if (!cpurst_b)
      note_timeout("reset release");
  endtask

  task automatic wait_insts(input int n);
    int target;
    int guard;
    target = inst_count + n;
    guard  = 0;
    if (timeouts == 0)
    begin
      while ((inst_count < target) && (guard < WAIT_LIMIT))
      begin
        @(negedge sm_upd_clk);
        guard++;
      end
      if (inst_count < target)
        note_timeout($sformatf("%0d instructions", n));
    end
  endtask

  // a slow cycle with room left for a redirect before its answer
  task automatic wait_long_cycle();
    int guard;
    guard = 0;
    if (timeouts == 0)
    begin
      while (!(mem_busy && long_cyc && (ack_wait > 2)) && (guard < WAIT_LIMIT))
      begin
        @(negedge sm_upd_clk);
        guard++;
      end
      if (!(mem_busy && long_cyc && (ack_wait > 2)))
        note_timeout("slow bus cycle");
    end
  endtask

  task automatic wait_lpmd_ack();
    int guard;
    guard = 0;
    if (timeouts == 0)
    begin
      while (!lpmd_ack && (guard < WAIT_LIMIT))
      begin
        @(negedge sm_upd_clk);
        guard++;
      end
      if (!lpmd_ack)
        note_timeout("low power acknowledge");
    end
  endtask

  task automatic issue_redirect(input hw_addr_t target);
    to_drive_point();
    redirect_vld  = 1'b1;
    redirect_addr = target;
    fetch_en      = 1'b1;
    to_drive_point();
    redirect_vld  = 1'b0;
  endtask

  task automatic check_reached(input int seen, input string what);
    if (seen == 0)
      report_rule($sformatf("the run never reached %s", what));
  endtask

  initial
  begin
    void'($urandom(32'h32f4_4536));
    errors = 0;
    timeouts = 0;
    inst_count = 0;
    unalign_seen = 0;
    wide_seen = 0;
    err_seen = 0;
    flight_seen = 0;
    lpmd_seen = 0;
    redirect_vld = 1'b0;
    redirect_addr = '0;
    fetch_en = 1'b0;
    lpmd_req = 1'b0;
    long_ack = 1'b0;
    mem_busy = 1'b0;
    long_cyc = 1'b0;
    ack_wait = 0;
    wb_ack = 1'b0;
    wb_err = 1'b0;
    wb_dat = '0;

    wait_reset_release();
    issue_redirect(START_HW);  // sequential words with the error word in the middle
    wait_insts(16);
    issue_redirect(ODD_HW);
    wait_insts(6);

    to_drive_point();
    long_ack = 1'b1;           // queue fills behind the slow cycle
    wait_long_cycle();
    issue_redirect(FLIGHT_HW);
    long_ack = 1'b0;
    wait_insts(6);

    to_drive_point();
    lpmd_req = 1'b1;
    wait_lpmd_ack();
    hold_cycles(12);
    lpmd_req = 1'b0;
    wait_insts(4);
    fetch_en = 1'b0;
    hold_cycles(20);

    check_reached(unalign_seen, "an unaligned first word");
    check_reached(wide_seen, "a 32-bit instruction");
    check_reached(err_seen, "a bus error");
    check_reached(flight_seen, "a redirect during a bus cycle");
    check_reached(lpmd_seen, "a low power acknowledge");

    $display("checks done: %0d errors, %0d timeouts, %0d instructions delivered",
             errors, timeouts, inst_count);
    if ((errors == 0) && (timeouts == 0))
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: sim.f
logic/ibus_pkg.sv
logic/fetch_pkg.sv
logic/fetch_addr_gen.sv
logic/fetch_req_queue.sv
logic/ibus_master.sv
logic/ifu_ibusif.sv
test/tb_clkgen.sv
test/tb_ifu_ibusif.sv

// File: Makefile
# Verilator simulation of the instruction fetch bus interface

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

# a simulation that exits with an error counts as a failed run
test:
	verilator --binary --timing --assert -f sim.f --top-module tb_ifu_ibusif -Mdir obj_dir
	./obj_dir/Vtb_ifu_ibusif > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
